//--- include/ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Queue depth, also works at 4 or 16
`define ISQ_SIZE 8

`define PHYS_REGS 32
`define PHYS_ADDR_W 5
`define ROB_ADDR_W 4

// Slots per cycle for dispatch, issue and writeback
`define DISPATCH_WIDTH 2
`define XLEN 32

`endif

//--- hdl/ooo_pkg.sv
`include "ooo_defs.svh"

package ooo_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_cmd_t;

  typedef enum logic {
    OP2_REG,
    OP2_IMM
  } op2_kind_t;

  typedef struct packed {
    logic                    en;
    alu_cmd_t                alu_cmd;
    logic [`PHYS_ADDR_W-1:0] src1;
    logic [`PHYS_ADDR_W-1:0] src2;
    op2_kind_t               op2_kind;
    logic [`XLEN-1:0]        imm;
    logic [`PHYS_ADDR_W-1:0] phys_rd;
    logic [`ROB_ADDR_W-1:0]  rob_addr;
  } dispatch_slot_t;

  // While an operand is not ready, its low bits hold the source tag
  typedef struct packed {
    logic                    valid;
    alu_cmd_t                alu_cmd;
    logic [`XLEN-1:0]        op1;
    logic [`XLEN-1:0]        op2;
    logic                    op1_ready;
    logic                    op2_ready;
    logic [`PHYS_ADDR_W-1:0] phys_rd;
    logic [`ROB_ADDR_W-1:0]  rob_addr;
  } isq_entry_t;

  typedef struct packed {
    logic                    valid;
    alu_cmd_t                alu_cmd;
    logic [`XLEN-1:0]        op1;
    logic [`XLEN-1:0]        op2;
    logic [`PHYS_ADDR_W-1:0] phys_rd;
    logic [`ROB_ADDR_W-1:0]  rob_addr;
  } issue_slot_t;

  typedef struct packed {
    logic                    valid;
    logic [`PHYS_ADDR_W-1:0] phys_rd;
    logic [`ROB_ADDR_W-1:0]  rob_addr;
    logic [`XLEN-1:0]        data;
  } wb_slot_t;

endpackage

//--- hdl/busy_table.sv
`include "ooo_defs.svh"

module busy_table import ooo_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst,
  input  dispatch_slot_t [`DISPATCH_WIDTH-1:0]  dispatch,
  input  wb_slot_t [`DISPATCH_WIDTH-1:0]        wb,
  output logic [2*`DISPATCH_WIDTH-1:0]          src_ready
);

  logic [`PHYS_REGS-1:0] busy;

  always_comb begin
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      src_ready[2*s]   = !busy[dispatch[s].src1];
      src_ready[2*s+1] = !busy[dispatch[s].src2];
      // Result arriving this cycle counts as ready
      for (int w = 0; w < `DISPATCH_WIDTH; w++) begin
        if (wb[w].valid && wb[w].phys_rd == dispatch[s].src1) src_ready[2*s] = 1'b1;
        if (wb[w].valid && wb[w].phys_rd == dispatch[s].src2) src_ready[2*s+1] = 1'b1;
      end
      // An older slot of the same group produces this source
      for (int p = 0; p < s; p++) begin
        if (dispatch[p].en && dispatch[p].phys_rd == dispatch[s].src1) src_ready[2*s] = 1'b0;
        if (dispatch[p].en && dispatch[p].phys_rd == dispatch[s].src2) src_ready[2*s+1] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      for (int w = 0; w < `DISPATCH_WIDTH; w++) begin
        if (wb[w].valid) busy[wb[w].phys_rd] <= 1'b0;
      end
      // Fresh rename of the same tag overrides the clear
      for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
        if (dispatch[s].en) busy[dispatch[s].phys_rd] <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/phys_regfile.sv
`include "ooo_defs.svh"

module phys_regfile import ooo_pkg::*; (
  input  logic                                              clk,
  input  logic                                              rst,
  input  wb_slot_t [`DISPATCH_WIDTH-1:0]                    wb,
  input  logic [2*`DISPATCH_WIDTH-1:0][`PHYS_ADDR_W-1:0]    rd_tag,
  output logic [2*`DISPATCH_WIDTH-1:0][`XLEN-1:0]           rd_data
);

  logic [`XLEN-1:0] regs [`PHYS_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int w = 0; w < `DISPATCH_WIDTH; w++) begin
        if (wb[w].valid) regs[wb[w].phys_rd] <= wb[w].data;
      end
    end
  end

  // Writeback data of this cycle bypasses the array
  always_comb begin
    for (int r = 0; r < 2*`DISPATCH_WIDTH; r++) begin
      rd_data[r] = regs[rd_tag[r]];
      for (int w = 0; w < `DISPATCH_WIDTH; w++) begin
        if (wb[w].valid && wb[w].phys_rd == rd_tag[r]) begin
          rd_data[r] = wb[w].data;
        end
      end
    end
  end

endmodule

//--- hdl/issue_queue.sv
`include "ooo_defs.svh"

module issue_queue import ooo_pkg::*; #(
  parameter int size = `ISQ_SIZE
) (
  input  logic                                clk,
  input  logic                                rst,
  input  isq_entry_t [`DISPATCH_WIDTH-1:0]    enq,
  output logic                                full,
  input  wb_slot_t [`DISPATCH_WIDTH-1:0]      wb,
  output issue_slot_t [`DISPATCH_WIDTH-1:0]   issue
);

  localparam int IDX_W = $clog2(size);
  localparam int CNT_W = $clog2(size + 1);

  // Entry 0 is the oldest, valid entries are packed from index 0
  isq_entry_t q  [size];
  isq_entry_t nq [size];

  logic [size-1:0]            ready;
  logic [IDX_W-1:0]           sel [`DISPATCH_WIDTH];
  logic [`DISPATCH_WIDTH-1:0] has;
  logic [CNT_W-1:0]           count;
  logic [CNT_W-1:0]           n_iss;
  logic [CNT_W-1:0]           post;

  function automatic isq_entry_t wake(isq_entry_t e, wb_slot_t [`DISPATCH_WIDTH-1:0] w);
    isq_entry_t r;
    r = e;
    for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
      if (w[k].valid && !e.op1_ready && e.op1[`PHYS_ADDR_W-1:0] == w[k].phys_rd) begin
        r.op1       = w[k].data;
        r.op1_ready = 1'b1;
      end
      if (w[k].valid && !e.op2_ready && e.op2[`PHYS_ADDR_W-1:0] == w[k].phys_rd) begin
        r.op2       = w[k].data;
        r.op2_ready = 1'b1;
      end
    end
    return r;
  endfunction

  // Oldest-first select of up to two ready entries
  always_comb begin
    int found;
    found = 0;
    count = '0;
    has   = '0;
    for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
      sel[k] = '0;
    end
    for (int i = 0; i < size; i++) begin
      ready[i] = q[i].valid && q[i].op1_ready && q[i].op2_ready;
      count    = count + CNT_W'(q[i].valid);
      if (ready[i] && found < `DISPATCH_WIDTH) begin
        sel[found] = IDX_W'(i);
        has[found] = 1'b1;
        found++;
      end
    end
    n_iss = CNT_W'(found);
    post  = count - n_iss;
  end

  assign full = int'(post) > size - `DISPATCH_WIDTH;

  always_comb begin
    int   dst;
    int   pos;
    logic gone;
    for (int j = 0; j < size; j++) begin
      nq[j] = '0;
    end
    // Survivors shift down past the issued entries and pick up wakeups
    for (int i = 0; i < size; i++) begin
      dst  = i;
      gone = 1'b0;
      for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
        if (has[k] && IDX_W'(i) > sel[k]) dst--;
        if (has[k] && IDX_W'(i) == sel[k]) gone = 1'b1;
      end
      if (q[i].valid && !gone) nq[dst] = wake(q[i], wb);
    end
    // New ops go behind the survivors
    pos = int'(post);
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      if (enq[s].valid && !full) begin
        nq[pos] = enq[s];
        pos++;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < size; i++) begin
      q[i] <= nq[i];
      if (rst) q[i].valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
      issue[k].alu_cmd  <= q[sel[k]].alu_cmd;
      issue[k].op1      <= q[sel[k]].op1;
      issue[k].op2      <= q[sel[k]].op2;
      issue[k].phys_rd  <= q[sel[k]].phys_rd;
      issue[k].rob_addr <= q[sel[k]].rob_addr;
      if (rst) begin
        issue[k].valid <= 1'b0;
      end else begin
        issue[k].valid <= has[k];
      end
    end
  end

endmodule

//--- hdl/alu_pipe.sv
`include "ooo_defs.svh"

module alu_pipe import ooo_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  issue_slot_t issue,
  output wb_slot_t    wb
);

  logic [`XLEN-1:0] result;

  always_comb begin
    case (issue.alu_cmd)
      ALU_ADD: result = issue.op1 + issue.op2;
      ALU_SUB: result = issue.op1 - issue.op2;
      ALU_AND: result = issue.op1 & issue.op2;
      ALU_OR:  result = issue.op1 | issue.op2;
      ALU_XOR: result = issue.op1 ^ issue.op2;
      ALU_SLL: result = issue.op1 << issue.op2[4:0];
      ALU_SRL: result = issue.op1 >> issue.op2[4:0];
      // Signed compare
      ALU_SLT: result = `XLEN'($signed(issue.op1) < $signed(issue.op2));
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    wb.phys_rd  <= issue.phys_rd;
    wb.rob_addr <= issue.rob_addr;
    wb.data     <= result;
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= issue.valid;
    end
  end

endmodule

//--- hdl/issue_exec_top.sv
`include "ooo_defs.svh"

module issue_exec_top import ooo_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst,
  input  dispatch_slot_t [`DISPATCH_WIDTH-1:0]  dispatch,
  output logic                                  isq_full,
  output wb_slot_t [`DISPATCH_WIDTH-1:0]        wb
);

  logic [2*`DISPATCH_WIDTH-1:0]                   src_ready;
  logic [2*`DISPATCH_WIDTH-1:0][`PHYS_ADDR_W-1:0] rd_tag;
  logic [2*`DISPATCH_WIDTH-1:0][`XLEN-1:0]        rd_data;
  isq_entry_t [`DISPATCH_WIDTH-1:0]               enq;
  issue_slot_t [`DISPATCH_WIDTH-1:0]              issue;

  // Ready operands carry data, waiting ones carry their tag
  always_comb begin
    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
      rd_tag[2*s]         = dispatch[s].src1;
      rd_tag[2*s+1]       = dispatch[s].src2;
      enq[s].valid        = dispatch[s].en;
      enq[s].alu_cmd      = dispatch[s].alu_cmd;
      enq[s].phys_rd      = dispatch[s].phys_rd;
      enq[s].rob_addr     = dispatch[s].rob_addr;
      enq[s].op1_ready    = src_ready[2*s];
      enq[s].op1          = src_ready[2*s] ? rd_data[2*s] : `XLEN'(dispatch[s].src1);
      if (dispatch[s].op2_kind == OP2_IMM) begin
        enq[s].op2_ready  = 1'b1;
        enq[s].op2        = dispatch[s].imm;
      end else begin
        enq[s].op2_ready  = src_ready[2*s+1];
        enq[s].op2        = src_ready[2*s+1] ? rd_data[2*s+1] : `XLEN'(dispatch[s].src2);
      end
    end
  end

  busy_table i_busy_table (.clk, .rst, .dispatch, .wb, .src_ready);

  phys_regfile i_regfile (.clk, .rst, .wb, .rd_tag, .rd_data);

  issue_queue #(.size(`ISQ_SIZE)) i_isq (
    .clk, .rst, .enq, .full(isq_full), .wb, .issue
  );

  for (genvar g = 0; g < `DISPATCH_WIDTH; g++) begin : g_alu
    alu_pipe i_alu (.clk, .rst, .issue(issue[g]), .wb(wb[g]));
  end

endmodule

//--- test/tb_issue_exec.sv
`include "ooo_defs.svh"

module tb_issue_exec import ooo_pkg::*; ();

  localparam int NTAGS    = `PHYS_REGS;
  localparam int NROB     = 1 << `ROB_ADDR_W;
  localparam int M_INDEP  = 0;
  localparam int M_CHAIN  = 1;
  localparam int M_RANDOM = 2;
  localparam int M_ZERO   = 3;
  localparam logic [`XLEN-1:0] SIGN = {1'b1, {(`XLEN-1){1'b0}}};

  logic                                 clk;
  logic                                 rst;
  dispatch_slot_t [`DISPATCH_WIDTH-1:0] disp;
  logic                                 isq_full;
  wb_slot_t [`DISPATCH_WIDTH-1:0]       wb;

  logic [31:0] lfsr;

  // Model state per physical tag, tag 0 stays a constant zero
  logic [`XLEN-1:0] mval [NTAGS];
  bit               live [NTAGS];
  bit               done [NTAGS];
  int               readers [NTAGS];
  int               free_q [$];
  int               last_rd;

  // In-flight ops keyed by ROB address
  bit               op_valid [NROB];
  alu_cmd_t         op_cmd [NROB];
  int               op_rd [NROB];
  int               op_s1 [NROB];
  int               op_s2 [NROB];
  bit               op_s2_reg [NROB];
  bit               a_known [NROB];
  bit               b_known [NROB];
  logic [`XLEN-1:0] a_val [NROB];
  logic [`XLEN-1:0] b_val [NROB];

  int inflight;
  int completed;
  int errors;
  int tests_run;
  int tests_failed;
  int full_cycles;
  bit timed_out;

  issue_exec_top i_dut (.clk, .rst, .dispatch(disp), .isq_full, .wb);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Galois LFSR, one step per bit
  function automatic logic [31:0] take(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic logic [`XLEN-1:0] alu_model(input alu_cmd_t c,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    case (c)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      // Flipping the sign bits turns a signed compare into an unsigned one
      ALU_SLT: return ((a ^ SIGN) < (b ^ SIGN)) ? `XLEN'(1) : '0;
      default: return '0;
    endcase
  endfunction

  function automatic int pick_tag(input bit want_free, input bit need_done, input int excl);
    int start;
    int t;
    start = int'(take(5));
    for (int i = 0; i < NTAGS; i++) begin
      t = (start + i) % NTAGS;
      if (t != excl) begin
        if (want_free ? !live[t] : (live[t] && (done[t] || !need_done))) return t;
      end
    end
    return 0;
  endfunction

  task automatic release_tag(input int t);
    if (t != 0 && live[t] && done[t] && readers[t] == 0) begin
      live[t] = 1'b0;
      free_q.push_back(t);
    end
  endtask

  task automatic model_reset();
    free_q.delete();
    for (int t = 0; t < NTAGS; t++) begin
      mval[t]    = '0;
      live[t]    = (t == 0);
      done[t]    = 1'b1;
      readers[t] = 0;
      if (t != 0) free_q.push_back(t);
    end
    for (int r = 0; r < NROB; r++) begin
      op_valid[r] = 1'b0;
    end
    inflight = 0;
    last_rd  = 0;
  endtask

  task automatic check_wb();
    int               r;
    int               t;
    logic [`XLEN-1:0] expv;
    for (int w = 0; w < `DISPATCH_WIDTH; w++) begin
      if (wb[w].valid) begin
        r = int'(wb[w].rob_addr);
        if (!op_valid[r]) begin
          $display("Error: writeback for rob %0d, which is not in flight", r);
          errors++;
        end else begin
          if (!a_known[r] || !b_known[r]) begin
            $display("Error: rob %0d wrote back before its operands were produced", r);
            errors++;
          end
          expv = alu_model(op_cmd[r], a_val[r], b_val[r]);
          if (int'(wb[w].phys_rd) != op_rd[r]) begin
            $display("Fail wb[%0d].phys_rd rob %0d: expected %0h got %0h",
                     w, r, op_rd[r], wb[w].phys_rd);
            errors++;
          end
          if (wb[w].data !== expv) begin
            $display("Fail wb[%0d].data rob %0d: expected %h got %h", w, r, expv, wb[w].data);
            errors++;
          end
          t = op_rd[r];
          mval[t] = expv;
          done[t] = 1'b1;
          // Waiting consumers pick up the value
          for (int k = 0; k < NROB; k++) begin
            if (op_valid[k] && !a_known[k] && op_s1[k] == t) begin
              a_known[k] = 1'b1;
              a_val[k]   = expv;
            end
            if (op_valid[k] && !b_known[k] && op_s2_reg[k] && op_s2[k] == t) begin
              b_known[k] = 1'b1;
              b_val[k]   = expv;
            end
          end
          op_valid[r] = 1'b0;
          inflight--;
          completed++;
          readers[op_s1[r]]--;
          release_tag(op_s1[r]);
          if (op_s2_reg[r]) begin
            readers[op_s2[r]]--;
            release_tag(op_s2[r]);
          end
          release_tag(t);
        end
      end
    end
  endtask

  task automatic step();
    @(negedge clk);
    check_wb();
  endtask

  task automatic make_op(input int s, input int mode, output bit ok);
    int               r;
    int               rd;
    int               s1;
    int               s2;
    bit               s2_reg;
    logic [31:0]      rv;
    logic [`XLEN-1:0] imm;
    r  = -1;
    ok = 1'b0;
    for (int k = NROB - 1; k >= 0; k--) begin
      if (!op_valid[k]) r = k;
    end
    if (r >= 0 && free_q.size() > 0) begin
      rd = free_q.pop_front();
      live[rd] = 1'b1;
      done[rd] = 1'b0;
      rv = take(3);
      s2_reg = (mode == M_CHAIN || mode == M_RANDOM) && take(1) == 1;
      s2 = 0;
      case (mode)
        M_INDEP: s1 = pick_tag(1'b0, 1'b1, rd);
        M_CHAIN: s1 = (live[last_rd] && last_rd != rd) ? last_rd : pick_tag(1'b0, 1'b0, rd);
        M_ZERO:  s1 = pick_tag(1'b1, 1'b0, rd);
        default: s1 = pick_tag(1'b0, 1'b0, rd);
      endcase
      if (s2_reg) s2 = pick_tag(1'b0, 1'b0, rd);
      imm = s2_reg ? '0 : take(`XLEN);

      disp[s].en       = 1'b1;
      disp[s].alu_cmd  = alu_cmd_t'(rv[2:0]);
      disp[s].src1     = `PHYS_ADDR_W'(s1);
      disp[s].src2     = `PHYS_ADDR_W'(s2);
      disp[s].op2_kind = s2_reg ? OP2_REG : OP2_IMM;
      disp[s].imm      = imm;
      disp[s].phys_rd  = `PHYS_ADDR_W'(rd);
      disp[s].rob_addr = `ROB_ADDR_W'(r);

      op_valid[r]  = 1'b1;
      op_cmd[r]    = alu_cmd_t'(rv[2:0]);
      op_rd[r]     = rd;
      op_s1[r]     = s1;
      op_s2[r]     = s2;
      op_s2_reg[r] = s2_reg;
      a_known[r]   = done[s1];
      a_val[r]     = mval[s1];
      b_known[r]   = !s2_reg || done[s2];
      b_val[r]     = s2_reg ? mval[s2] : imm;
      readers[s1]++;
      if (s2_reg) readers[s2]++;
      last_rd = rd;
      inflight++;
      ok = 1'b1;
    end
  endtask

  task automatic run_ops(input int n, input int mode, input bit drain);
    int sent;
    int cycles;
    int limit;
    bit ok;
    bit en;
    sent   = 0;
    cycles = 0;
    limit  = n * `ISQ_SIZE + 100;
    while (!timed_out && (sent < n || (drain && inflight > 0))) begin
      step();
      cycles++;
      disp = '0;
      if (isq_full) full_cycles++;
      if (cycles > limit) begin
        $display("Error: timeout after %0d cycles, %0d of %0d ops sent, %0d never completed",
                 cycles, sent, n, inflight);
        errors++;
        timed_out = 1'b1;
      end else if (!isq_full) begin
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
          en = (mode == M_RANDOM) ? (take(2) != 0) : (mode != M_ZERO || s == 0);
          if (sent < n && en) begin
            make_op(s, mode, ok);
            if (ok) sent++;
          end
        end
      end
    end
  endtask

  task automatic apply_reset();
    rst  = 1'b1;
    disp = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    model_reset();
  endtask

  // Two ready ops into an empty queue come back two edges later
  task automatic paired_latency();
    int                     ra;
    int                     rb;
    int                     ga;
    int                     gb;
    bit                     ok0;
    bit                     ok1;
    step();
    disp = '0;
    make_op(0, M_INDEP, ok0);
    make_op(1, M_INDEP, ok1);
    ra = int'(disp[0].rob_addr);
    rb = int'(disp[1].rob_addr);
    if (!ok0 || !ok1) begin
      $display("Error: the pair could not be dispatched into the empty queue");
      errors++;
    end
    // Nothing may come back after the dispatch edge or the issue edge
    for (int k = 1; k <= 2; k++) begin
      step();
      disp = '0;
      if (wb[0].valid || wb[1].valid) begin
        $display("Fail wb.valid cycle %0d: expected 0 got %0h", k, {wb[1].valid, wb[0].valid});
        errors++;
      end
    end
    step();
    disp = '0;
    ga = int'(wb[0].rob_addr);
    gb = int'(wb[1].rob_addr);
    if (!(wb[0].valid && wb[1].valid)) begin
      $display("Fail wb.valid: expected 3 got %0h", {wb[1].valid, wb[0].valid});
      errors++;
    end else if (!((ga == ra && gb == rb) || (ga == rb && gb == ra))) begin
      $display("Fail wb.rob_addr: expected %0h/%0h got %0h/%0h", ra, rb, ga, gb);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    int e;
    int f;
    lfsr         = 32'h4448;
    rst          = 1'b1;
    disp         = '0;
    errors       = 0;
    completed    = 0;
    tests_run    = 0;
    tests_failed = 0;
    full_cycles  = 0;
    timed_out    = 1'b0;
    apply_reset();

    e = errors;
    run_ops(40, M_INDEP, 1'b1);
    end_test("independent ops", e);

    if (!timed_out) begin
      e = errors;
      run_ops(60, M_CHAIN, 1'b1);
      end_test("dependent chains", e);
    end

    if (!timed_out) begin
      e = errors;
      paired_latency();
      end_test("paired dispatch latency", e);
    end

    if (!timed_out) begin
      e = errors;
      f = full_cycles;
      run_ops(300, M_RANDOM, 1'b1);
      if (!timed_out && full_cycles == f) begin
        $display("Error: isq_full never rose, so dispatch was never held back");
        errors++;
      end
      end_test("long random run", e);
    end

    if (!timed_out) begin
      e = errors;
      run_ops(30, M_RANDOM, 1'b0);
      apply_reset();
      if (wb[0].valid || wb[1].valid) begin
        $display("Fail wb.valid after reset: expected 0 got %0h", {wb[1].valid, wb[0].valid});
        errors++;
      end
      if (isq_full) begin
        $display("Fail isq_full after reset: expected 0 got %0h", isq_full);
        errors++;
      end
      run_ops(24, M_ZERO, 1'b1);
      end_test("reset mid-run", e);
    end

    $display("tests run %0d, failed %0d, ops completed %0d, isq_full cycles %0d, errors %0d",
             tests_run, tests_failed, completed, full_cycles, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
hdl/ooo_pkg.sv
hdl/busy_table.sv
hdl/phys_regfile.sv
hdl/issue_queue.sv
hdl/alu_pipe.sv
hdl/issue_exec_top.sv
test/tb_issue_exec.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_issue_exec
FILELIST  = files.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG)
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
